/* dispatch_core.f */
common/dispatch_pkg.sv
design/dispatch/dispatch.sv
design/issue_queue/issue_queue.sv
design/exec_unit.sv
design/cdb_arbiter.sv
design/result_file.sv
design/dispatch_core.sv
dv/dispatch_core_assertions.sv
dv/dispatch_core_tb.sv

/* dv/dispatch_core_tb.sv */
`timescale 1ns/10ps

module dispatch_core_tb;

import dispatch_pkg::*;

localparam int IQ_DEPTH    = 4;
localparam int PKT_TOTAL   = 46;
localparam int CYCLE_LIMIT = 4 * PKT_TOTAL + 200;

logic           clk;
logic           rst_n;
logic           flush;
logic [1:0]     rn_valid;
fu_kind_t [1:0] rn_kind;
alu_op_t  [1:0] rn_op;
preg_t    [1:0] rn_dst;
preg_t    [3:0] rn_src;
logic [3:0]     rn_src_rdy;
word_t    [3:0] rn_arf_data;
logic [3:0]     rn_use_imm;
word_t    [1:0] rn_imm;
logic           rn_pkt_valid;
logic           rn_pkt_ready;
logic [1:0]     cdb_valid;
preg_t    [1:0] cdb_dst;
word_t    [1:0] cdb_data;

// reference model, one entry per physical register
word_t       exp_val [NUM_PREG];
logic        pend    [NUM_PREG];
int          pend_cnt;
logic [31:0] rng;
preg_t       next_dst;
string       cur_test;
int          errors;
int          test_err0;
int          tests;
int          checks;
int          cycles;
int          stalls;

dispatch_core #(
    .IQ_DEPTH (IQ_DEPTH)
) DUT (
    .clk            (clk),
    .rst_n_i        (rst_n),
    .flush_i        (flush),
    .rn_valid_i     (rn_valid),
    .rn_kind_i      (rn_kind),
    .rn_op_i        (rn_op),
    .rn_dst_i       (rn_dst),
    .rn_src_i       (rn_src),
    .rn_src_rdy_i   (rn_src_rdy),
    .rn_arf_data_i  (rn_arf_data),
    .rn_use_imm_i   (rn_use_imm),
    .rn_imm_i       (rn_imm),
    .rn_pkt_valid_i (rn_pkt_valid),
    .rn_pkt_ready_o (rn_pkt_ready),
    .cdb_valid_o    (cdb_valid),
    .cdb_dst_o      (cdb_dst),
    .cdb_data_o     (cdb_data)
);

always #10 clk = ~clk;

function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
endfunction

// expected unit output straight from the operation rules
function automatic word_t model_result(fu_kind_t kind, alu_op_t op, word_t a, word_t b);
    word_t r;
    if (kind == FU_MDU) begin
        r = a * b;
    end else if (kind == FU_LSU) begin
        r = a + b;
    end else begin
        case (op)
            OP_ADD:  r = a + b;
            OP_SUB:  r = a - b;
            OP_AND:  r = a & b;
            OP_OR:   r = a | b;
            OP_XOR:  r = a ^ b;
            OP_SLL:  r = a << b[4:0];
            OP_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: r = a * b;
        endcase
    end
    return r;
endfunction

// one renamed instruction with ready operands and a fresh destination
task automatic fill_slot(input int s, input fu_kind_t kind, input alu_op_t op);
    rn_valid[s] = 1'b1;
    rn_kind[s]  = kind;
    rn_op[s]    = op;
    rn_dst[s]   = next_dst;
    next_dst    = next_dst + 1'b1;
    rn_imm[s]   = next_rand();
    for (int o = 0; o < 2; o++) begin
        rn_src[2*s+o]      = preg_t'(next_rand());
        rn_src_rdy[2*s+o]  = 1'b1;
        rn_arf_data[2*s+o] = next_rand();
        rn_use_imm[2*s+o]  = (o == 1) && ((next_rand() & 32'd1) != 0);
    end
endtask

// operand i waits on register p
task automatic depend(input int i, input preg_t p);
    rn_src[i]     = p;
    rn_src_rdy[i] = 1'b0;
endtask

task automatic clear_slots();
    rn_valid   = 2'b00;
    rn_src_rdy = 4'hf;
    rn_use_imm = 4'h0;
endtask

task automatic record_packet();
    word_t opv [2];
    int    i;
    for (int s = 0; s < 2; s++) begin
        if (rn_valid[s]) begin
            for (int o = 0; o < 2; o++) begin
                i = 2 * s + o;
                if (rn_src_rdy[i]) begin
                    opv[o] = rn_use_imm[i] ? rn_imm[s] : rn_arf_data[i];
                end else begin
                    opv[o] = exp_val[rn_src[i]];
                end
            end
            exp_val[rn_dst[s]] = model_result(rn_kind[s], rn_op[s], opv[0], opv[1]);
            pend[rn_dst[s]]    = 1'b1;
            pend_cnt++;
        end
    end
endtask

task automatic offer();
    rn_pkt_valid = 1'b1;
    @(posedge clk);
    while (!rn_pkt_ready) begin
        stalls++;
        @(posedge clk);
    end
    @(negedge clk);
    rn_pkt_valid = 1'b0;
    record_packet();
    clear_slots();
endtask

task automatic drain();
    while (pend_cnt != 0) begin
        @(negedge clk);
    end
endtask

// anything still pending after the flush edge must never show up
task automatic pulse_flush(output int killed);
    flush = 1'b1;
    @(posedge clk);
    @(negedge clk);
    flush  = 1'b0;
    killed = 0;
    for (int p = 0; p < NUM_PREG; p++) begin
        if (pend[p]) begin
            pend[p] = 1'b0;
            pend_cnt--;
            killed++;
        end
    end
endtask

task automatic start_test(input string name);
    cur_test  = name;
    test_err0 = errors;
endtask

task automatic end_test();
    tests++;
    $display("test %-12s done, %0d errors", cur_test, errors - test_err0);
endtask

always @(posedge clk) begin : cdb_monitor
    preg_t d;
    if (rst_n) begin
        for (int c = 0; c < 2; c++) begin
            if (cdb_valid[c]) begin
                d = cdb_dst[c];
                assert (pend[d]) else begin
                    $display("%s: p%0d broadcast with no instruction waiting for it",
                             cur_test, d);
                    errors++;
                end
                if (pend[d]) begin
                    checks++;
                    assert (cdb_data[c] == exp_val[d]) else begin
                        $display("** Error %s: p%0d expected %h actual %h",
                                 cur_test, d, exp_val[d], cdb_data[c]);
                        errors++;
                    end
                    pend[d] = 1'b0;
                    pend_cnt--;
                end
            end
        end
    end
end

always @(posedge clk) begin : watchdog
    cycles++;
    if (cycles == CYCLE_LIMIT) begin
        $display("timeout after %0d cycles in %s, %0d instructions never broadcast",
                 cycles, cur_test, pend_cnt);
        $display("SIMULATION FAILED");
        $finish;
    end
end

initial begin
    preg_t prod [2];
    int    killed;
    clk          = 1'b0;
    rst_n        = 1'b0;
    flush        = 1'b0;
    rn_pkt_valid = 1'b0;
    rn_valid     = 2'b00;
    for (int s = 0; s < 2; s++) begin
        rn_kind[s] = FU_ALU;
        rn_op[s]   = OP_ADD;
    end
    rn_dst      = '0;
    rn_src      = '0;
    rn_src_rdy  = 4'hf;
    rn_arf_data = '0;
    rn_use_imm  = 4'h0;
    rn_imm      = '0;
    rng         = 32'hd7f0f024;
    next_dst    = '0;
    pend_cnt    = 0;
    errors      = 0;
    test_err0   = 0;
    tests       = 0;
    checks      = 0;
    cycles      = 0;
    stalls      = 0;
    cur_test    = "reset";
    for (int p = 0; p < NUM_PREG; p++) begin
        pend[p]    = 1'b0;
        exp_val[p] = '0;
    end
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    start_test("ready");
    for (int n = 0; n < 8; n++) begin
        fill_slot(0, FU_ALU, alu_op_t'(3'(next_rand() % 7)));
        fill_slot(1, FU_ALU, alu_op_t'(3'(next_rand() % 7)));
        offer();
    end
    // valid packet with no valid slot
    offer();
    drain();
    end_test();

    start_test("steering");
    for (int n = 0; n < 2; n++) begin
        fill_slot(0, FU_ALU, alu_op_t'(3'(next_rand() % 7)));
        fill_slot(1, FU_ALU, alu_op_t'(3'(next_rand() % 7)));
        offer();
        fill_slot(0, FU_MDU, OP_MUL);
        fill_slot(1, FU_MDU, OP_MUL);
        offer();
        fill_slot(0, FU_LSU, OP_ADD);
        fill_slot(1, FU_LSU, OP_ADD);
        offer();
    end
    drain();
    end_test();

    start_test("dependence");
    for (int n = 0; n < 3; n++) begin
        // slot 1 waits on slot 0 of the same packet
        fill_slot(0, FU_ALU, OP_ADD);
        fill_slot(1, FU_ALU, OP_SUB);
        depend(2, rn_dst[0]);
        prod[0] = rn_dst[0];
        prod[1] = rn_dst[1];
        offer();
        // producers still in flight, wakeup or bypass
        fill_slot(0, FU_MDU, OP_MUL);
        depend(0, prod[1]);
        fill_slot(1, FU_LSU, OP_ADD);
        depend(3, prod[0]);
        prod[0] = rn_dst[0];
        prod[1] = rn_dst[1];
        offer();
        drain();
        // producers complete, values come from the result store
        fill_slot(0, FU_ALU, OP_XOR);
        depend(0, prod[0]);
        depend(1, prod[1]);
        fill_slot(1, FU_LSU, OP_ADD);
        depend(2, prod[1]);
        offer();
        drain();
    end
    end_test();

    start_test("backpressure");
    stalls = 0;
    for (int n = 0; n < 16; n++) begin
        fill_slot(0, FU_MDU, OP_MUL);
        fill_slot(1, FU_MDU, OP_MUL);
        offer();
    end
    assert (stalls > 0) else begin
        $display("%s: rn_pkt_ready_o never dropped under a run of MDU packets", cur_test);
        errors++;
    end
    drain();
    end_test();

    start_test("flush");
    for (int n = 0; n < 3; n++) begin
        fill_slot(0, FU_MDU, OP_MUL);
        fill_slot(1, FU_MDU, OP_MUL);
        offer();
    end
    pulse_flush(killed);
    assert (killed > 0) else begin
        $display("%s: no instruction was still waiting when the flush hit", cur_test);
        errors++;
    end
    for (int n = 0; n < 3; n++) begin
        fill_slot(0, FU_ALU, alu_op_t'(3'(next_rand() % 7)));
        fill_slot(1, FU_LSU, OP_ADD);
        offer();
    end
    drain();
    end_test();

    $display("%0d tests, %0d results checked, %0d errors, %0d assertion failures",
             tests, checks, errors, DUT.u_assert.fail_cnt);
    if (errors == 0 && DUT.u_assert.fail_cnt == 0) begin
        $display("SIMULATION PASSED");
    end else begin
        $display("SIMULATION FAILED");
    end
    $finish;
end

endmodule

/* dv/dispatch_core_assertions.sv */
`timescale 1ns/10ps

module dispatch_core_assertions (
    input logic                        clk,
    input logic                        rst_n_i,
    input logic                        flush_i,
    input logic                        rn_pkt_ready_i,
    input logic [1:0]                  cdb_valid_i,
    input dispatch_pkg::preg_t [1:0]   cdb_dst_i
);

int fail_cnt = 0;

// cdb stays quiet while reset is held
cdb_quiet_in_reset: assert property (
    @(posedge clk) !rst_n_i |-> (cdb_valid_i == 2'b00)
) else begin
    $error("CDB valid while reset is asserted");
    fail_cnt++;
end

// one destination is never broadcast twice in a cycle
cdb_distinct_dst: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    (&cdb_valid_i) |-> (cdb_dst_i[0] != cdb_dst_i[1])
) else begin
    $error("both CDB slots carry p%0d", cdb_dst_i[0]);
    fail_cnt++;
end

// acceptance blocked for the cycle after a flush
no_accept_after_flush: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    flush_i |=> !rn_pkt_ready_i
) else begin
    $error("rn_pkt_ready_o high in the cycle after flush");
    fail_cnt++;
end

endmodule

bind dispatch_core dispatch_core_assertions u_assert (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .flush_i        (flush_i),
    .rn_pkt_ready_i (rn_pkt_ready_o),
    .cdb_valid_i    (cdb_valid_o),
    .cdb_dst_i      (cdb_dst_o)
);

/* design/dispatch_core.sv */
`timescale 1ns/10ps

module dispatch_core #(
    parameter int IQ_DEPTH = 4
) (
    input  logic                             clk,
    input  logic                             rst_n_i,
    input  logic                             flush_i,
    input  logic [1:0]                       rn_valid_i,
    input  dispatch_pkg::fu_kind_t [1:0]     rn_kind_i,
    input  dispatch_pkg::alu_op_t  [1:0]     rn_op_i,
    input  dispatch_pkg::preg_t    [1:0]     rn_dst_i,
    input  dispatch_pkg::preg_t    [3:0]     rn_src_i,
    input  logic [3:0]                       rn_src_rdy_i,
    input  dispatch_pkg::word_t    [3:0]     rn_arf_data_i,
    input  logic [3:0]                       rn_use_imm_i,
    input  dispatch_pkg::word_t    [1:0]     rn_imm_i,
    input  logic                             rn_pkt_valid_i,
    output logic                             rn_pkt_ready_o,
    output logic [1:0]                       cdb_valid_o,
    output dispatch_pkg::preg_t    [1:0]     cdb_dst_o,
    output dispatch_pkg::word_t    [1:0]     cdb_data_o
);

import dispatch_pkg::*;

// lane q pairs queue q with the unit of the same index
localparam fu_kind_t UNIT_KIND [4] = '{FU_ALU, FU_ALU, FU_MDU, FU_LSU};

logic [3:0]      iq_room;
logic            iq_wr_en;
logic [3:0][1:0] iq_choose;
alu_op_t [1:0]   iq_op;
preg_t   [1:0]   iq_dst;
preg_t   [3:0]   iq_src;
word_t   [3:0]   iq_data;
logic [3:0]      iq_data_rdy;
preg_t   [3:0]   rf_src;
word_t   [3:0]   rf_data;
logic [3:0]      rf_cmp;
logic [3:0]      iss_valid;
logic [3:0]      iss_ready;
alu_op_t [3:0]   iss_op;
word_t   [3:0]   iss_a;
word_t   [3:0]   iss_b;
preg_t   [3:0]   iss_dst;
logic [3:0]      res_valid;
logic [3:0]      res_grant;
preg_t   [3:0]   res_dst;
word_t   [3:0]   res_data;

dispatch u_dispatch (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .flush_i        (flush_i),
    .rn_valid_i     (rn_valid_i),
    .rn_kind_i      (rn_kind_i),
    .rn_op_i        (rn_op_i),
    .rn_dst_i       (rn_dst_i),
    .rn_src_i       (rn_src_i),
    .rn_src_rdy_i   (rn_src_rdy_i),
    .rn_arf_data_i  (rn_arf_data_i),
    .rn_use_imm_i   (rn_use_imm_i),
    .rn_imm_i       (rn_imm_i),
    .rn_pkt_valid_i (rn_pkt_valid_i),
    .cdb_valid_i    (cdb_valid_o),
    .cdb_dst_i      (cdb_dst_o),
    .cdb_data_i     (cdb_data_o),
    .rf_data_i      (rf_data),
    .rf_cmp_i       (rf_cmp),
    .iq_room_i      (iq_room),
    .rf_src_o       (rf_src),
    .rn_pkt_ready_o (rn_pkt_ready_o),
    .iq_wr_en_o     (iq_wr_en),
    .iq_choose_o    (iq_choose),
    .iq_op_o        (iq_op),
    .iq_dst_o       (iq_dst),
    .iq_src_o       (iq_src),
    .iq_data_o      (iq_data),
    .iq_data_rdy_o  (iq_data_rdy)
);

for (genvar q = 0; q < 4; q++) begin : g_lane
    issue_queue #(
        .IQ_DEPTH (IQ_DEPTH)
    ) u_iq (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .wr_en_i     (iq_wr_en),
        .choose_i    (iq_choose[q]),
        .op_i        (iq_op),
        .dst_i       (iq_dst),
        .src_i       (iq_src),
        .data_i      (iq_data),
        .data_rdy_i  (iq_data_rdy),
        .cdb_valid_i (cdb_valid_o),
        .cdb_dst_i   (cdb_dst_o),
        .cdb_data_i  (cdb_data_o),
        .iss_ready_i (iss_ready[q]),
        .room_o      (iq_room[q]),
        .iss_valid_o (iss_valid[q]),
        .iss_op_o    (iss_op[q]),
        .iss_a_o     (iss_a[q]),
        .iss_b_o     (iss_b[q]),
        .iss_dst_o   (iss_dst[q])
    );

    exec_unit #(
        .KIND (UNIT_KIND[q])
    ) u_eu (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .iss_valid_i (iss_valid[q]),
        .iss_op_i    (iss_op[q]),
        .iss_a_i     (iss_a[q]),
        .iss_b_i     (iss_b[q]),
        .iss_dst_i   (iss_dst[q]),
        .res_grant_i (res_grant[q]),
        .iss_ready_o (iss_ready[q]),
        .res_valid_o (res_valid[q]),
        .res_dst_o   (res_dst[q]),
        .res_data_o  (res_data[q])
    );
end

cdb_arbiter u_arb (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .res_valid_i (res_valid),
    .res_dst_i   (res_dst),
    .res_data_i  (res_data),
    .res_grant_o (res_grant),
    .cdb_valid_o (cdb_valid_o),
    .cdb_dst_o   (cdb_dst_o),
    .cdb_data_o  (cdb_data_o)
);

result_file u_rf (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .cdb_valid_i (cdb_valid_o),
    .cdb_dst_i   (cdb_dst_o),
    .cdb_data_i  (cdb_data_o),
    .rd_src_i    (rf_src),
    .rd_data_o   (rf_data),
    .rd_cmp_o    (rf_cmp)
);

endmodule

/* design/result_file.sv */
`timescale 1ns/10ps

module result_file (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic [1:0]                  cdb_valid_i,
    input  dispatch_pkg::preg_t [1:0]   cdb_dst_i,
    input  dispatch_pkg::word_t [1:0]   cdb_data_i,
    input  dispatch_pkg::preg_t [3:0]   rd_src_i,
    output dispatch_pkg::word_t [3:0]   rd_data_o,
    output logic [3:0]                  rd_cmp_o
);

import dispatch_pkg::*;

word_t               mem_q [NUM_PREG];
logic [NUM_PREG-1:0] cmp_q;

always_ff @(posedge clk) begin
    for (int s = 0; s < 2; s++) begin
        if (cdb_valid_i[s]) begin
            mem_q[cdb_dst_i[s]] <= cdb_data_i[s];
        end
    end
end

// complete bits only set here, flush leaves them alone
always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
        cmp_q <= '0;
    end else begin
        for (int s = 0; s < 2; s++) begin
            if (cdb_valid_i[s]) begin
                cmp_q[cdb_dst_i[s]] <= 1'b1;
            end
        end
    end
end

always_comb begin
    for (int i = 0; i < 4; i++) begin
        rd_data_o[i] = mem_q[rd_src_i[i]];
        rd_cmp_o[i]  = cmp_q[rd_src_i[i]];
    end
end

endmodule

/* design/cdb_arbiter.sv */
`timescale 1ns/10ps

module cdb_arbiter (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic [3:0]                  res_valid_i,
    input  dispatch_pkg::preg_t [3:0]   res_dst_i,
    input  dispatch_pkg::word_t [3:0]   res_data_i,
    output logic [3:0]                  res_grant_o,
    output logic [1:0]                  cdb_valid_o,
    output dispatch_pkg::preg_t [1:0]   cdb_dst_o,
    output dispatch_pkg::word_t [1:0]   cdb_data_o
);

import dispatch_pkg::*;

logic [1:0] ptr_q;
logic [1:0] ptr_n;
logic [1:0] idx;

// walk from the pointer, fill slot 0 then slot 1
always_comb begin
    res_grant_o = '0;
    cdb_valid_o = '0;
    cdb_dst_o   = '0;
    cdb_data_o  = '0;
    ptr_n       = ptr_q;
    idx         = ptr_q;
    for (int i = 0; i < 4; i++) begin
        if (res_valid_i[idx] && !cdb_valid_o[1]) begin
            if (!cdb_valid_o[0]) begin
                cdb_valid_o[0] = 1'b1;
                cdb_dst_o[0]   = res_dst_i[idx];
                cdb_data_o[0]  = res_data_i[idx];
            end else begin
                cdb_valid_o[1] = 1'b1;
                cdb_dst_o[1]   = res_dst_i[idx];
                cdb_data_o[1]  = res_data_i[idx];
            end
            res_grant_o[idx] = 1'b1;
            ptr_n            = idx + 2'd1;
        end
        idx = idx + 2'd1;
    end
end

always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
        ptr_q <= 2'd0;
    end else begin
        ptr_q <= ptr_n;
    end
end

endmodule

/* design/exec_unit.sv */
`timescale 1ns/10ps

module exec_unit #(
    parameter dispatch_pkg::fu_kind_t KIND = dispatch_pkg::FU_ALU
) (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   flush_i,
    input  logic                   iss_valid_i,
    input  dispatch_pkg::alu_op_t  iss_op_i,
    input  dispatch_pkg::word_t    iss_a_i,
    input  dispatch_pkg::word_t    iss_b_i,
    input  dispatch_pkg::preg_t    iss_dst_i,
    input  logic                   res_grant_i,
    output logic                   iss_ready_o,
    output logic                   res_valid_o,
    output dispatch_pkg::preg_t    res_dst_o,
    output dispatch_pkg::word_t    res_data_o
);

import dispatch_pkg::*;

word_t result;
logic  take;

// free again once the held result is granted
assign iss_ready_o = ~res_valid_o | res_grant_i;
assign take        = iss_valid_i & iss_ready_o;

always_comb begin
    case (KIND)
        FU_MDU:  result = iss_a_i * iss_b_i;
        FU_LSU:  result = iss_a_i + iss_b_i;
        default: begin
            case (iss_op_i)
                OP_ADD:  result = iss_a_i + iss_b_i;
                OP_SUB:  result = iss_a_i - iss_b_i;
                OP_AND:  result = iss_a_i & iss_b_i;
                OP_OR:   result = iss_a_i | iss_b_i;
                OP_XOR:  result = iss_a_i ^ iss_b_i;
                OP_SLL:  result = iss_a_i << iss_b_i[4:0];
                OP_SLT:  result = {31'd0, $signed(iss_a_i) < $signed(iss_b_i)};
                default: result = iss_a_i * iss_b_i;
            endcase
        end
    endcase
end

always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
        res_valid_o <= 1'b0;
    end else if (flush_i) begin
        res_valid_o <= 1'b0;
    end else if (take) begin
        res_valid_o <= 1'b1;
    end else if (res_grant_i) begin
        res_valid_o <= 1'b0;
    end
end

always_ff @(posedge clk) begin
    if (take) begin
        res_dst_o  <= iss_dst_i;
        res_data_o <= result;
    end
end

endmodule

/* design/issue_queue/issue_queue.sv */
`timescale 1ns/10ps

module issue_queue #(
    parameter int IQ_DEPTH = 4
) (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  logic                           flush_i,
    input  logic                           wr_en_i,
    input  logic [1:0]                     choose_i,
    input  dispatch_pkg::alu_op_t [1:0]    op_i,
    input  dispatch_pkg::preg_t   [1:0]    dst_i,
    input  dispatch_pkg::preg_t   [3:0]    src_i,
    input  dispatch_pkg::word_t   [3:0]    data_i,
    input  logic [3:0]                     data_rdy_i,
    input  logic [1:0]                     cdb_valid_i,
    input  dispatch_pkg::preg_t   [1:0]    cdb_dst_i,
    input  dispatch_pkg::word_t   [1:0]    cdb_data_i,
    input  logic                           iss_ready_i,
    output logic                           room_o,
    output logic                           iss_valid_o,
    output dispatch_pkg::alu_op_t          iss_op_o,
    output dispatch_pkg::word_t            iss_a_o,
    output dispatch_pkg::word_t            iss_b_o,
    output dispatch_pkg::preg_t            iss_dst_o
);

import dispatch_pkg::*;

// entries kept packed toward index 0, which is the oldest
logic [IQ_DEPTH-1:0] vld_q;
logic [IQ_DEPTH-1:0] vld_n;
alu_op_t             op_q   [IQ_DEPTH];
alu_op_t             op_n   [IQ_DEPTH];
preg_t               dst_q  [IQ_DEPTH];
preg_t               dst_n  [IQ_DEPTH];
preg_t [1:0]         src_q  [IQ_DEPTH];
preg_t [1:0]         src_n  [IQ_DEPTH];
word_t [1:0]         data_q [IQ_DEPTH];
word_t [1:0]         data_n [IQ_DEPTH];
logic  [1:0]         rdy_q  [IQ_DEPTH];
logic  [1:0]         rdy_n  [IQ_DEPTH];

int   sel_idx;
int   nxt;
int   tail;
logic shift;
logic fire;

// packed order means the last two being free is the same as two free
assign room_o = ~vld_q[IQ_DEPTH-2];

// oldest entry with both operands ready
always_comb begin
    iss_valid_o = 1'b0;
    sel_idx     = 0;
    for (int k = IQ_DEPTH - 1; k >= 0; k--) begin
        if (vld_q[k] && (&rdy_q[k])) begin
            iss_valid_o = 1'b1;
            sel_idx     = k;
        end
    end
end

assign iss_op_o  = op_q[sel_idx];
assign iss_a_o   = data_q[sel_idx][0];
assign iss_b_o   = data_q[sel_idx][1];
assign iss_dst_o = dst_q[sel_idx];
assign fire      = iss_valid_o & iss_ready_i;

always_comb begin
    tail = 0;
    for (int k = 0; k < IQ_DEPTH; k++) begin
        // close the gap left by the issued entry
        shift     = fire && (k >= sel_idx);
        nxt       = (shift && (k != IQ_DEPTH - 1)) ? k + 1 : k;
        vld_n[k]  = vld_q[nxt] & ~(shift && (k == IQ_DEPTH - 1));
        op_n[k]   = op_q[nxt];
        dst_n[k]  = dst_q[nxt];
        src_n[k]  = src_q[nxt];
        data_n[k] = data_q[nxt];
        rdy_n[k]  = rdy_q[nxt];

        // cdb wakeup
        for (int o = 0; o < 2; o++) begin
            for (int c = 0; c < 2; c++) begin
                if (!rdy_n[k][o] && cdb_valid_i[c] && (cdb_dst_i[c] == src_n[k][o])) begin
                    rdy_n[k][o]  = 1'b1;
                    data_n[k][o] = cdb_data_i[c];
                end
            end
        end
        if (vld_n[k]) begin
            tail++;
        end
    end

    // new slots land behind every current entry, slot 0 first
    for (int s = 0; s < 2; s++) begin
        if (wr_en_i && choose_i[s]) begin
            for (int k = 0; k < IQ_DEPTH; k++) begin
                if (k == tail) begin
                    vld_n[k]  = 1'b1;
                    op_n[k]   = op_i[s];
                    dst_n[k]  = dst_i[s];
                    src_n[k]  = src_i[2*s +: 2];
                    data_n[k] = data_i[2*s +: 2];
                    rdy_n[k]  = data_rdy_i[2*s +: 2];
                end
            end
            tail++;
        end
    end
end

always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
        vld_q <= '0;
    end else if (flush_i) begin
        vld_q <= '0;
    end else begin
        vld_q <= vld_n;
    end
end

always_ff @(posedge clk) begin
    op_q   <= op_n;
    dst_q  <= dst_n;
    src_q  <= src_n;
    data_q <= data_n;
    rdy_q  <= rdy_n;
end

endmodule

/* design/dispatch/dispatch.sv */
`timescale 1ns/10ps

module dispatch (
    input  logic                             clk,
    input  logic                             rst_n_i,
    input  logic                             flush_i,
    input  logic [1:0]                       rn_valid_i,
    input  dispatch_pkg::fu_kind_t [1:0]     rn_kind_i,
    input  dispatch_pkg::alu_op_t  [1:0]     rn_op_i,
    input  dispatch_pkg::preg_t    [1:0]     rn_dst_i,
    input  dispatch_pkg::preg_t    [3:0]     rn_src_i,
    input  logic [3:0]                       rn_src_rdy_i,
    input  dispatch_pkg::word_t    [3:0]     rn_arf_data_i,
    input  logic [3:0]                       rn_use_imm_i,
    input  dispatch_pkg::word_t    [1:0]     rn_imm_i,
    input  logic                             rn_pkt_valid_i,
    input  logic [1:0]                       cdb_valid_i,
    input  dispatch_pkg::preg_t    [1:0]     cdb_dst_i,
    input  dispatch_pkg::word_t    [1:0]     cdb_data_i,
    input  dispatch_pkg::word_t    [3:0]     rf_data_i,
    input  logic [3:0]                       rf_cmp_i,
    input  logic [3:0]                       iq_room_i,
    output dispatch_pkg::preg_t    [3:0]     rf_src_o,
    output logic                             rn_pkt_ready_o,
    output logic                             iq_wr_en_o,
    output logic [3:0][1:0]                  iq_choose_o,
    output dispatch_pkg::alu_op_t  [1:0]     iq_op_o,
    output dispatch_pkg::preg_t    [1:0]     iq_dst_o,
    output dispatch_pkg::preg_t    [3:0]     iq_src_o,
    output dispatch_pkg::word_t    [3:0]     iq_data_o,
    output logic [3:0]                       iq_data_rdy_o
);

import dispatch_pkg::*;

// set for one cycle after a flush and out of reset
logic blk_q;

always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
        blk_q <= 1'b1;
    end else begin
        blk_q <= flush_i;
    end
end

// every queue must be able to take a full packet
assign rn_pkt_ready_o = (&iq_room_i) & ~flush_i & ~blk_q;
assign iq_wr_en_o     = rn_pkt_valid_i & rn_pkt_ready_o;

assign rf_src_o = rn_src_i;
assign iq_src_o = rn_src_i;
assign iq_op_o  = rn_op_i;
assign iq_dst_o = rn_dst_i;

// operand select, lowest priority first so later hits win
always_comb begin
    for (int i = 0; i < 4; i++) begin
        iq_data_o[i]     = rf_data_i[i];
        iq_data_rdy_o[i] = rf_cmp_i[i];
        for (int c = 0; c < 2; c++) begin
            if (cdb_valid_i[c] && (cdb_dst_i[c] == rn_src_i[i])) begin
                iq_data_o[i]     = cdb_data_i[c];
                iq_data_rdy_o[i] = 1'b1;
            end
        end
        if (rn_src_rdy_i[i]) begin
            iq_data_o[i]     = rn_use_imm_i[i] ? rn_imm_i[i/2] : rn_arf_data_i[i];
            iq_data_rdy_o[i] = 1'b1;
        end
    end
end

// alu split by destination parity, mdu and lsu may take both slots
always_comb begin
    iq_choose_o = '0;
    for (int s = 0; s < 2; s++) begin
        if (rn_valid_i[s]) begin
            case (rn_kind_i[s])
                FU_ALU: begin
                    if (rn_dst_i[s][0]) begin
                        iq_choose_o[IQ_ALU1][s] = 1'b1;
                    end else begin
                        iq_choose_o[IQ_ALU0][s] = 1'b1;
                    end
                end
                FU_MDU:  iq_choose_o[IQ_MDU][s] = 1'b1;
                FU_LSU:  iq_choose_o[IQ_LSU][s] = 1'b1;
                default: iq_choose_o[IQ_ALU0][s] = 1'b0;
            endcase
        end
    end
end

endmodule

/* common/dispatch_pkg.sv */
package dispatch_pkg;

    localparam int XLEN     = 32;
    localparam int NUM_PREG = 64;
    localparam int PREG_W   = $clog2(NUM_PREG);

    // queue order as seen by dispatch and the top level
    localparam int IQ_ALU0 = 0;
    localparam int IQ_ALU1 = 1;
    localparam int IQ_MDU  = 2;
    localparam int IQ_LSU  = 3;

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [PREG_W-1:0] preg_t;

    // alu codes plus mul-low for the mdu
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_SLL = 3'd5,
        OP_SLT = 3'd6,
        OP_MUL = 3'd7
    } alu_op_t;

    typedef enum logic [1:0] {
        FU_ALU = 2'd0,
        FU_MDU = 2'd1,
        FU_LSU = 2'd2
    } fu_kind_t;

endpackage
